// ==== source/lsu_pkg.sv ====
package lsu_pkg;

  localparam int ADDR_W    = 10;   // Word address
  localparam int DATA_W    = 32;
  localparam int TAG_W     = 6;
  localparam int NUM_PIPES = 2;    // Round-robin arbiter is built for two

  // Load queue entry state
  typedef enum logic [1:0] {
    EMPTY  = 2'd0,
    WAIT   = 2'd1,   // Allocated, needs issue or replay
    ISSUED = 2'd2,   // Owned by a load pipe
    DONE   = 2'd3    // Data captured, waiting to retire
  } ldq_state_e;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
  } disp_t;

  typedef struct packed {
    logic              valid;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // Pipe result, conflict means replay
  typedef struct packed {
    logic              valid;
    logic              conflict;
    logic [DATA_W-1:0] data;
  } pipe_update_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } done_rpt_t;

endpackage

// ==== source/data_mem.sv ====
`timescale 1ns/1ps

module data_mem import lsu_pkg::*; (
  input  logic              i_clk,
  input  mem_req_t          i_req,
  output logic [DATA_W-1:0] o_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] r_mem [DEPTH];

  // Single port, read data registered and held on writes
  always_ff @(posedge i_clk) begin
    if (i_req.valid) begin
      if (i_req.wr) begin
        r_mem[i_req.addr] <= i_req.wdata;
      end else begin
        o_rdata <= r_mem[i_req.addr];
      end
    end
  end

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  mem_req_t             i_wr_req,
  input  mem_req_t             i_pipe_req [NUM_PIPES],
  output logic [NUM_PIPES-1:0] o_pipe_gnt,
  output mem_req_t             o_mem_req
);

  logic r_last_gnt;   // Pipe granted most recently

  always_comb begin
    o_pipe_gnt = '0;
    if (!i_wr_req.valid) begin
      if (i_pipe_req[0].valid && i_pipe_req[1].valid) begin
        o_pipe_gnt[0] = r_last_gnt;
        o_pipe_gnt[1] = !r_last_gnt;
      end else begin
        o_pipe_gnt[0] = i_pipe_req[0].valid;
        o_pipe_gnt[1] = i_pipe_req[1].valid;
      end
    end
  end

  always_comb begin
    o_mem_req = '0;
    if (i_wr_req.valid) o_mem_req = i_wr_req;   // External write always wins
    else if (o_pipe_gnt[0]) o_mem_req = i_pipe_req[0];
    else if (o_pipe_gnt[1]) o_mem_req = i_pipe_req[1];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last_gnt <= 1'b0;
    end else if (|o_pipe_gnt) begin
      r_last_gnt <= o_pipe_gnt[1];
    end
  end

  a_gnt_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0({i_wr_req.valid, o_pipe_gnt}));

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_gnt_chk
    a_gnt_to_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_pipe_gnt[p] |-> i_pipe_req[p].valid);
  end

endmodule

// ==== source/load_pipe.sv ====
`timescale 1ns/1ps

module load_pipe import lsu_pkg::*; #(
  parameter int  LDQ_SIZE = 4,
  localparam int IDX_W    = $clog2(LDQ_SIZE)
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_issue_valid,
  input  logic [IDX_W-1:0]  i_issue_index,
  input  logic [ADDR_W-1:0] i_issue_addr,
  output mem_req_t          o_mem_req,
  input  logic              i_mem_gnt,
  input  logic [DATA_W-1:0] i_mem_rdata,
  output pipe_update_t      o_update,
  output logic [IDX_W-1:0]  o_update_index
);

  logic              r_s1_valid;
  logic [IDX_W-1:0]  r_s1_index;
  logic [ADDR_W-1:0] r_s1_addr;
  logic              r_s2_valid;
  logic [IDX_W-1:0]  r_s2_index;

  logic w_refused;
  logic w_hold;

  assign w_refused = r_s1_valid && !i_mem_gnt;
  assign w_hold    = w_refused && r_s2_valid;   // Update port busy with data, retry

  always_comb begin
    o_mem_req       = '0;
    o_mem_req.valid = r_s1_valid;
    o_mem_req.addr  = r_s1_addr;
  end

  // Stage 2 data beats a stage 1 conflict
  always_comb begin
    o_update       = '0;
    o_update_index = r_s2_index;
    if (r_s2_valid) begin
      o_update.valid = 1'b1;
      o_update.data  = i_mem_rdata;
    end else if (w_refused) begin
      o_update.valid    = 1'b1;
      o_update.conflict = 1'b1;
      o_update_index    = r_s1_index;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      if (!w_hold) r_s1_valid <= i_issue_valid;
      r_s2_valid <= r_s1_valid && i_mem_gnt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue_valid && !w_hold) begin
      r_s1_index <= i_issue_index;
      r_s1_addr  <= i_issue_addr;
    end
    if (r_s1_valid && i_mem_gnt) r_s2_index <= r_s1_index;
  end

  // Queue must hold off issue while stage 1 retries
  a_no_issue_on_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_hold |-> !i_issue_valid);

endmodule

// ==== source/load_queue.sv ====
`timescale 1ns/1ps

module load_queue import lsu_pkg::*; #(
  parameter int  LDQ_SIZE = 4,
  localparam int IDX_W    = $clog2(LDQ_SIZE)
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_disp_valid,
  input  disp_t                i_disp,
  output logic                 o_ldq_full,
  output logic [NUM_PIPES-1:0] o_issue_valid,
  output logic [IDX_W-1:0]     o_issue_index [NUM_PIPES],
  output logic [ADDR_W-1:0]    o_issue_addr [NUM_PIPES],
  input  pipe_update_t         i_update [NUM_PIPES],
  input  logic [IDX_W-1:0]     i_update_index [NUM_PIPES],
  output done_rpt_t            o_done
);

  ldq_state_e        r_state [LDQ_SIZE];
  logic [TAG_W-1:0]  r_tag [LDQ_SIZE];
  logic [ADDR_W-1:0] r_addr [LDQ_SIZE];
  logic [DATA_W-1:0] r_data [LDQ_SIZE];

  logic [IDX_W-1:0]  r_in_ptr;
  logic [IDX_W-1:0]  r_out_ptr;
  logic [IDX_W:0]    r_count;

  logic [LDQ_SIZE-1:0]  w_alloc;
  logic [LDQ_SIZE-1:0]  w_issue_hit;
  logic [LDQ_SIZE-1:0]  w_upd_hit;
  logic [LDQ_SIZE-1:0]  w_upd_conflict;
  logic [DATA_W-1:0]    w_upd_data [LDQ_SIZE];
  logic [NUM_PIPES-1:0] w_data_return;

  assign o_ldq_full = (r_count == (IDX_W+1)'(LDQ_SIZE));

  // =========================================================================
  // Issue pick, lowest WAIT entry of each pipe's parity
  // =========================================================================
  always_comb begin
    for (int p = 0; p < NUM_PIPES; p++) begin
      // Pipe returning data may need stage 1 for a refused load
      w_data_return[p] = i_update[p].valid && !i_update[p].conflict;
      o_issue_valid[p] = 1'b0;
      o_issue_index[p] = '0;
      for (int i = LDQ_SIZE - 1; i >= 0; i--) begin
        if ((i % NUM_PIPES) == p && r_state[i] == WAIT) begin
          o_issue_valid[p] = 1'b1;
          o_issue_index[p] = IDX_W'(i);
        end
      end
      if (w_data_return[p]) begin
        o_issue_valid[p] = 1'b0;
      end
      o_issue_addr[p] = r_addr[o_issue_index[p]];
    end
  end

  // Per-entry decode of allocation, issue and pipe updates
  always_comb begin
    for (int i = 0; i < LDQ_SIZE; i++) begin
      w_alloc[i]        = i_disp_valid && (r_in_ptr == IDX_W'(i));
      w_issue_hit[i]    = 1'b0;
      w_upd_hit[i]      = 1'b0;
      w_upd_conflict[i] = 1'b0;
      w_upd_data[i]     = '0;
      for (int p = 0; p < NUM_PIPES; p++) begin
        if (o_issue_valid[p] && o_issue_index[p] == IDX_W'(i)) begin
          w_issue_hit[i] = 1'b1;
        end
        if (i_update[p].valid && i_update_index[p] == IDX_W'(i)) begin
          w_upd_hit[i]      = 1'b1;
          w_upd_conflict[i] = i_update[p].conflict;
          w_upd_data[i]     = i_update[p].data;
        end
      end
    end
  end

  // =========================================================================
  // Entry state machines
  // =========================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < LDQ_SIZE; i++) begin
        r_state[i] <= EMPTY;
      end
    end else begin
      for (int i = 0; i < LDQ_SIZE; i++) begin
        case (r_state[i])
          EMPTY:   if (w_alloc[i]) r_state[i] <= WAIT;
          WAIT:    if (w_issue_hit[i]) r_state[i] <= ISSUED;
          ISSUED:  if (w_upd_hit[i]) r_state[i] <= w_upd_conflict[i] ? WAIT : DONE;
          DONE:    if (o_done.valid && r_out_ptr == IDX_W'(i)) r_state[i] <= EMPTY;
          default: r_state[i] <= EMPTY;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int i = 0; i < LDQ_SIZE; i++) begin
      if (w_alloc[i]) begin
        r_tag[i]  <= i_disp.tag;
        r_addr[i] <= i_disp.addr;
      end
      if (w_upd_hit[i] && !w_upd_conflict[i]) begin
        r_data[i] <= w_upd_data[i];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_count   <= '0;
    end else begin
      if (i_disp_valid) r_in_ptr <= r_in_ptr + 1'b1;
      if (o_done.valid) r_out_ptr <= r_out_ptr + 1'b1;
      case ({i_disp_valid, o_done.valid})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // In-order retirement from the out-pointer
  always_comb begin
    o_done.valid = (r_state[r_out_ptr] == DONE);
    o_done.tag   = r_tag[r_out_ptr];
    o_done.data  = r_data[r_out_ptr];
  end

  a_no_disp_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> !o_ldq_full);

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_upd_chk
    a_update_on_issued: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_update[p].valid |-> r_state[i_update_index[p]] == ISSUED);
  end

endmodule

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int  LDQ_SIZE = 4,
  localparam int IDX_W    = $clog2(LDQ_SIZE)
) (
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_disp_valid,
  input  disp_t     i_disp,
  output logic      o_ldq_full,
  input  mem_req_t  i_mem_wr,
  output done_rpt_t o_done
);

  logic [NUM_PIPES-1:0] w_issue_valid;
  logic [IDX_W-1:0]     w_issue_index [NUM_PIPES];
  logic [ADDR_W-1:0]    w_issue_addr [NUM_PIPES];
  pipe_update_t         w_update [NUM_PIPES];
  logic [IDX_W-1:0]     w_update_index [NUM_PIPES];
  mem_req_t             w_pipe_req [NUM_PIPES];
  logic [NUM_PIPES-1:0] w_pipe_gnt;
  mem_req_t             w_mem_req;
  logic [DATA_W-1:0]    w_mem_rdata;

  load_queue #(.LDQ_SIZE(LDQ_SIZE)) load_queue_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp         (i_disp),
    .o_ldq_full     (o_ldq_full),
    .o_issue_valid  (w_issue_valid),
    .o_issue_index  (w_issue_index),
    .o_issue_addr   (w_issue_addr),
    .i_update       (w_update),
    .i_update_index (w_update_index),
    .o_done         (o_done)
  );

  // =========================================================================
  // Load pipes, entry parity selects the pipe
  // =========================================================================
  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_pipe
    load_pipe #(.LDQ_SIZE(LDQ_SIZE)) load_pipe_i (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_issue_valid  (w_issue_valid[p]),
      .i_issue_index  (w_issue_index[p]),
      .i_issue_addr   (w_issue_addr[p]),
      .o_mem_req      (w_pipe_req[p]),
      .i_mem_gnt      (w_pipe_gnt[p]),
      .i_mem_rdata    (w_mem_rdata),
      .o_update       (w_update[p]),
      .o_update_index (w_update_index[p])
    );
  end

  mem_arbiter mem_arbiter_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wr_req   (i_mem_wr),
    .i_pipe_req (w_pipe_req),
    .o_pipe_gnt (w_pipe_gnt),
    .o_mem_req  (w_mem_req)
  );

  data_mem data_mem_i (
    .i_clk   (i_clk),
    .i_req   (w_mem_req),
    .o_rdata (w_mem_rdata)
  );

endmodule

// ==== test/lsu_checker.sv ====
`timescale 1ns/1ps

module lsu_checker import lsu_pkg::*; #(
  parameter int LDQ_SIZE = 4
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  disp_t            i_disp,
  input  logic             i_ldq_full,
  input  mem_req_t         i_mem_wr,
  input  done_rpt_t        i_done,
  output int               o_error_count,
  output int               o_outstanding,
  output int               o_retired,
  output logic [TAG_W-1:0] o_oldest_tag
);

  logic [DATA_W-1:0] model_mem [2**ADDR_W];   // Mirror of every external write
  disp_t             exp_q [$];                 // Loads in dispatch order

  // A load returns its own tag and the last word written at its address
  function automatic done_rpt_t expected_done(input disp_t ld);
    done_rpt_t rpt;
    rpt.valid = 1'b1;
    rpt.tag   = ld.tag;
    rpt.data  = model_mem[ld.addr];
    return rpt;
  endfunction

  always @(posedge i_clk or negedge i_reset_n) begin : compare
    done_rpt_t exp;
    if (!i_reset_n) begin
      exp_q.delete();
      o_outstanding = 0;
      o_retired     = 0;
    end else begin
      // Queue is full exactly when every entry holds a load
      if (i_ldq_full !== (o_outstanding == LDQ_SIZE)) begin
        $display("Mismatch at %0t: o_ldq_full expected %0b got %0b", $time,
                 o_outstanding == LDQ_SIZE, i_ldq_full);
        o_error_count++;
      end
      if (i_done.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: done report with tag %0h arrived with no pending load",
                   $time, i_done.tag);
          o_error_count++;
        end else begin
          exp = expected_done(exp_q.pop_front());
          if (i_done.tag !== exp.tag) begin
            $display("Mismatch at %0t: o_done.tag expected %0h got %0h", $time,
                     exp.tag, i_done.tag);
            o_error_count++;
          end
          if (i_done.data !== exp.data) begin
            $display("Mismatch at %0t: o_done.data expected %08h got %08h", $time,
                     exp.data, i_done.data);
            o_error_count++;
          end
          o_outstanding--;
          o_retired++;
        end
      end else if (i_done.valid !== 1'b0) begin
        $display("Error at %0t: o_done.valid is unknown", $time);
        o_error_count++;
      end
      if (i_disp_valid === 1'b1) begin
        exp_q.push_back(i_disp);
        o_outstanding++;
      end
      if (i_mem_wr.valid && i_mem_wr.wr) model_mem[i_mem_wr.addr] = i_mem_wr.wdata;
    end
    o_oldest_tag = (exp_q.size() != 0) ? exp_q[0].tag : '0;
  end

endmodule

// ==== test/tb_lsu_top.sv ====
`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*;;

  localparam int LDQ_SIZE      = 4;
  localparam int PRELOAD_WORDS = 64;   // Loads only read this preloaded window
  localparam int DRAIN_LIMIT   = 2000;
  localparam int STALL_LIMIT   = 500;

  logic      clk;
  logic      reset_n;
  logic      disp_valid;
  disp_t     disp;
  logic      ldq_full;
  mem_req_t  mem_wr;
  done_rpt_t done;

  int               chk_errors;
  int               outstanding;
  int               retired;
  logic [TAG_W-1:0] oldest_tag;
  int               errors;
  int               fail_base;
  int               tests_run;
  int               tests_failed;
  int               next_tag;
  int               retired_before;
  int               cycles;
  bit               loaded;

  always #5 clk = ~clk;

  lsu_top #(.LDQ_SIZE(LDQ_SIZE)) lsu_top_i (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp_valid (disp_valid),
    .i_disp       (disp),
    .o_ldq_full   (ldq_full),
    .i_mem_wr     (mem_wr),
    .o_done       (done)
  );

  lsu_checker #(.LDQ_SIZE(LDQ_SIZE)) lsu_checker_i (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_disp_valid  (disp_valid),
    .i_disp        (disp),
    .i_ldq_full    (ldq_full),
    .i_mem_wr      (mem_wr),
    .i_done        (done),
    .o_error_count (chk_errors),
    .o_outstanding (outstanding),
    .o_retired     (retired),
    .o_oldest_tag  (oldest_tag)
  );

  // ==========================================================================
  // Stimulus helpers, all driving on the falling edge
  // ==========================================================================
  task automatic drive_cycle(input bit want_load, input bit want_write, output bit sent);
    @(negedge clk);
    disp_valid = 1'b0;
    mem_wr     = '0;
    sent       = 1'b0;
    if (want_write) begin   // Upper half only, never hits a load address
      mem_wr.valid = 1'b1;
      mem_wr.wr    = 1'b1;
      mem_wr.addr  = ADDR_W'(512 + $urandom_range(511));
      mem_wr.wdata = $urandom;
    end
    if (want_load && !ldq_full) begin
      disp_valid = 1'b1;
      disp.tag   = TAG_W'(next_tag);
      disp.addr  = ADDR_W'($urandom_range(PRELOAD_WORDS - 1));
      next_tag++;
      sent = 1'b1;
    end
  endtask

  task automatic preload_memory();
    for (int a = 0; a < PRELOAD_WORDS; a++) begin
      @(negedge clk);
      mem_wr = '{valid: 1'b1, wr: 1'b1, addr: ADDR_W'(a), wdata: $urandom};
    end
    @(negedge clk);
    mem_wr = '0;
  endtask

  task automatic dispatch_loads(input int count);
    int sent_count = 0;
    int stalled    = 0;
    bit sent;
    while (sent_count < count && stalled < STALL_LIMIT) begin
      drive_cycle(1'b1, 1'b0, sent);
      if (sent) begin
        sent_count++;
        stalled = 0;
      end else begin
        stalled++;
      end
    end
    if (sent_count < count) begin
      $display("Timeout: queue stayed full, only %0d of %0d loads dispatched",
               sent_count, count);
      errors++;
    end
  endtask

  task automatic wait_for_drain();
    int waited = 0;
    bit sent;
    while (outstanding != 0 && waited < DRAIN_LIMIT) begin
      drive_cycle(1'b0, 1'b0, sent);
      waited++;
    end
    if (outstanding != 0) begin
      $display("Timeout: %0d loads starting at tag %0h never retired", outstanding, oldest_tag);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int failures;
    if (outstanding != 0) begin
      $display("Error: %0d loads still outstanding after test %s", outstanding, name);
      errors++;
    end
    failures = errors + chk_errors - fail_base;
    tests_run++;
    if (failures == 0) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, failures);
    end
    fail_base = errors + chk_errors;
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    clk        = 1'b0;
    reset_n    = 1'b0;
    disp_valid = 1'b0;
    disp       = '0;
    mem_wr     = '0;
    errors     = 0;
    fail_base  = 0;
    tests_run  = 0;
    next_tag   = 0;
    tests_failed = 0;
    void'($urandom(32'h9a39f3d1));
    repeat (16) @(negedge clk);
    reset_n = 1'b1;

    repeat (20) drive_cycle(1'b0, 1'b0, loaded);   // Checker flags any done or full
    end_test("reset idle");

    preload_memory();
    dispatch_loads(40);
    wait_for_drain();
    end_test("preload and in-order loads");

    // Write stream owns the memory, so every load replays
    retired_before = retired;
    cycles         = 0;
    while (!ldq_full && cycles < STALL_LIMIT) begin
      drive_cycle(1'b1, 1'b1, loaded);
      cycles++;
    end
    if (!ldq_full) begin
      $display("Timeout: load queue never filled under the write stream");
      errors++;
    end
    repeat (30) drive_cycle(1'b0, 1'b1, loaded);
    if (retired != retired_before) begin
      $display("Error: a load retired while the write stream blocked the memory");
      errors++;
    end
    wait_for_drain();
    end_test("write stream back-pressure");

    for (int c = 0; c < 300; c++) begin
      drive_cycle(1'b1, $urandom_range(1) == 1, loaded);
    end
    wait_for_drain();
    end_test("random loads and writes");

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d loads retired",
             tests_run, tests_failed, errors + chk_errors, retired);
    if (errors + chk_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== lsu_top.f ====
source/lsu_pkg.sv
source/data_mem.sv
source/mem_arbiter.sv
source/load_pipe.sv
source/load_queue.sv
source/lsu_top.sv
test/lsu_checker.sv
test/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the LSU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lsu_top -f lsu_top.f -o sim_lsu
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_lsu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
